// File: ebusPkg.sv
package ebusPkg;

  // bus geometry
  localparam int ebusDataWidth = 36;
  localparam int ebusSelWidth = 7;   // width of both cs and ds

  localparam int boardCount = 3;
  localparam int diagRegCount = 4;   // registers per diagnostic board
  localparam int diagRegIndexWidth = $clog2(diagRegCount);

  // controller select codes on cs
  localparam logic [ebusSelWidth-1:0] aprSelect = 7'o01;
  localparam logic [ebusSelWidth-1:0] cshSelect = 7'o02;
  localparam logic [ebusSelWidth-1:0] ctlSelect = 7'o03;

  // diagnostic function field sits in ds bits 6..4
  localparam int diagOpLsb = 4;
  localparam int diagOpWidth = 3;

  typedef enum logic [diagOpWidth-1:0] {
    diagRead  = 3'd1,
    diagWrite = 3'd2,
    diagClear = 3'd3
  } diagOp;

  // idle cycles in the wait phase before a read with no driver gives up
  localparam int diagTimeout = 16;
  localparam int diagCountWidth = $clog2(diagTimeout);

endpackage

// File: hostPkg.sv
package hostPkg;

  localparam int addrWidth = 8;
  localparam int axiDataWidth = 32;
  localparam int axiStrbWidth = axiDataWidth / 8;

  localparam logic [1:0] axiOkay = 2'b00;

  // register map
  localparam logic [addrWidth-1:0] regControl   = 8'h00;
  localparam logic [addrWidth-1:0] regSelect    = 8'h04;
  localparam logic [addrWidth-1:0] regWriteLow  = 8'h08;
  localparam logic [addrWidth-1:0] regWriteHigh = 8'h0C;
  localparam logic [addrWidth-1:0] regReadLow   = 8'h10;
  localparam logic [addrWidth-1:0] regReadHigh  = 8'h14;
  localparam logic [addrWidth-1:0] regStatus    = 8'h18;

  localparam int controlGo = 0;

  // regSelect fields
  localparam int selectCsLsb = 0;
  localparam int selectDsLsb = 8;

  localparam int statusBusy    = 0;
  localparam int statusDone    = 1;
  localparam int statusTimeout = 2;

  // diagnostic sequencer states
  typedef enum logic [1:0] {
    idleState,
    strobeState,
    waitState,
    doneState
  } seqState;

endpackage

// File: hostRegs.sv
`timescale 1ns/1ps

module hostRegs (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic [hostPkg::addrWidth-1:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [hostPkg::axiDataWidth-1:0] wdata,
  input  logic [hostPkg::axiStrbWidth-1:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  input  logic [hostPkg::addrWidth-1:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [hostPkg::axiDataWidth-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready,
  output logic start,
  output logic [ebusPkg::ebusSelWidth-1:0] csSel,
  output logic [ebusPkg::ebusSelWidth-1:0] dsSel,
  output logic [ebusPkg::ebusDataWidth-1:0] writeData,
  input  logic busy,
  input  logic done,
  input  logic timedOut,
  input  logic [ebusPkg::ebusDataWidth-1:0] readData
);

  localparam int highBits = ebusPkg::ebusDataWidth - hostPkg::axiDataWidth;

  logic writeAccept;
  logic readAccept;
  logic goWrite;
  logic [hostPkg::axiDataWidth-1:0] writeLow;
  logic [highBits-1:0] writeHigh;
  logic [ebusPkg::ebusDataWidth-1:0] resultData;
  logic doneFlag;
  logic timeoutFlag;
  logic [hostPkg::axiDataWidth-1:0] readMux;

  // byte lanes not enabled by wstrb keep their old value
  function automatic logic [hostPkg::axiDataWidth-1:0] mergeBytes(
    input logic [hostPkg::axiDataWidth-1:0] oldValue,
    input logic [hostPkg::axiDataWidth-1:0] newValue,
    input logic [hostPkg::axiStrbWidth-1:0] strb
  );
    logic [hostPkg::axiDataWidth-1:0] merged;
    merged = oldValue;
    for (int i = 0; i < hostPkg::axiStrbWidth; i++) begin
      if (strb[i]) merged[i*8 +: 8] = newValue[i*8 +: 8];
    end
    return merged;
  endfunction

  // address and data arrive together with only one write in flight
  assign writeAccept = awvalid && wvalid && !bvalid;
  assign awready = writeAccept;
  assign wready = writeAccept;
  assign bresp = hostPkg::axiOkay;

  assign arready = !rvalid;
  assign readAccept = arvalid && arready;
  assign rresp = hostPkg::axiOkay;

  assign goWrite = writeAccept && awaddr == hostPkg::regControl && wstrb[0] &&
                   wdata[hostPkg::controlGo] && !busy && !start;

  assign writeData = {writeHigh, writeLow};

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (writeAccept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      csSel <= '0;
      dsSel <= '0;
      writeLow <= '0;
      writeHigh <= '0;
    end else if (writeAccept) begin
      case (awaddr)
        hostPkg::regSelect: begin
          if (wstrb[0]) csSel <= wdata[hostPkg::selectCsLsb +: ebusPkg::ebusSelWidth];
          if (wstrb[1]) dsSel <= wdata[hostPkg::selectDsLsb +: ebusPkg::ebusSelWidth];
        end
        hostPkg::regWriteLow: writeLow <= mergeBytes(writeLow, wdata, wstrb);
        hostPkg::regWriteHigh: if (wstrb[0]) writeHigh <= wdata[highBits-1:0];
        default: ;  // control is handled below and the rest are read only
      endcase
    end
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      start <= 1'b0;
      doneFlag <= 1'b0;
      timeoutFlag <= 1'b0;
      resultData <= '0;
    end else begin
      start <= goWrite;
      if (goWrite) begin
        doneFlag <= 1'b0;
        timeoutFlag <= 1'b0;
      end else if (done) begin
        doneFlag <= 1'b1;
        timeoutFlag <= timedOut;
        resultData <= readData;
      end
    end
  end

  always_comb begin
    readMux = '0;
    case (araddr)
      hostPkg::regSelect: begin
        readMux[hostPkg::selectCsLsb +: ebusPkg::ebusSelWidth] = csSel;
        readMux[hostPkg::selectDsLsb +: ebusPkg::ebusSelWidth] = dsSel;
      end
      hostPkg::regWriteLow: readMux = writeLow;
      hostPkg::regWriteHigh: readMux[highBits-1:0] = writeHigh;
      hostPkg::regReadLow: readMux = resultData[hostPkg::axiDataWidth-1:0];
      hostPkg::regReadHigh: readMux[highBits-1:0] = resultData[ebusPkg::ebusDataWidth-1 -: highBits];
      hostPkg::regStatus: begin
        readMux[hostPkg::statusBusy] = busy || start;  // covers the cycle before busy rises
        readMux[hostPkg::statusDone] = doneFlag;
        readMux[hostPkg::statusTimeout] = timeoutFlag;
      end
      default: readMux = '0;  // go bit and unmapped offsets read 0
    endcase
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (readAccept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (readAccept) rdata <= readMux;
  end

endmodule

// File: diagSequencer.sv
`timescale 1ns/1ps

module diagSequencer (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic start,
  input  logic [ebusPkg::ebusSelWidth-1:0] csSel,
  input  logic [ebusPkg::ebusSelWidth-1:0] dsSel,
  input  logic [ebusPkg::ebusDataWidth-1:0] writeData,
  output logic [ebusPkg::ebusSelWidth-1:0] cs,
  output logic [ebusPkg::ebusSelWidth-1:0] ds,
  output logic diagStrobe,
  output logic readPhase,
  output logic [ebusPkg::ebusDataWidth-1:0] dataOut,
  input  logic dataValid,
  input  logic [ebusPkg::ebusDataWidth-1:0] ebusData,
  output logic busy,
  output logic done,
  output logic timedOut,
  output logic [ebusPkg::ebusDataWidth-1:0] readData
);

  localparam logic [ebusPkg::diagCountWidth-1:0] lastWait =
    ebusPkg::diagCountWidth'(ebusPkg::diagTimeout - 1);

  hostPkg::seqState state;
  ebusPkg::diagOp op;
  logic [ebusPkg::diagCountWidth-1:0] waitCount;
  logic responded;
  logic expired;

  assign op = ebusPkg::diagOp'(ds[ebusPkg::diagOpLsb +: ebusPkg::diagOpWidth]);

  assign diagStrobe = state == hostPkg::strobeState;
  assign readPhase = state == hostPkg::waitState;
  assign busy = state != hostPkg::idleState;

  // a read finishes in the cycle the mux shows a driver, or on the last wait cycle
  assign responded = readPhase && dataValid;
  assign expired = readPhase && !dataValid && waitCount == lastWait;

  assign done = state == hostPkg::doneState || responded || expired;
  assign timedOut = expired;
  assign readData = responded ? ebusData : '0;

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      state <= hostPkg::idleState;
      waitCount <= '0;
    end else begin
      case (state)
        hostPkg::idleState: if (start) state <= hostPkg::strobeState;
        hostPkg::strobeState: begin
          waitCount <= '0;
          state <= (op == ebusPkg::diagRead) ? hostPkg::waitState : hostPkg::doneState;
        end
        hostPkg::waitState: begin
          if (responded || expired) state <= hostPkg::idleState;
          else waitCount <= waitCount + 1'b1;
        end
        hostPkg::doneState: state <= hostPkg::idleState;
        default: state <= hostPkg::idleState;
      endcase
    end
  end

  // cs, ds and write data stay put until the next start
  always_ff @(posedge anyEBUSdriving) begin
    if (state == hostPkg::idleState && start) begin
      cs <= csSel;
      ds <= dsSel;
      dataOut <= writeData;
    end
  end

endmodule

// File: diagBoard.sv
`timescale 1ns/1ps

module diagBoard #(
  parameter logic [ebusPkg::ebusSelWidth-1:0] boardSelect = ebusPkg::aprSelect
) (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic [ebusPkg::ebusSelWidth-1:0] cs,
  input  logic [ebusPkg::ebusSelWidth-1:0] ds,
  input  logic diagStrobe,
  input  logic readPhase,
  input  logic [ebusPkg::ebusDataWidth-1:0] dataOut,
  output logic driving,
  output logic [ebusPkg::ebusDataWidth-1:0] data
);

  logic [ebusPkg::ebusDataWidth-1:0] diagRegs [ebusPkg::diagRegCount];
  logic selected;
  ebusPkg::diagOp op;
  logic [ebusPkg::diagRegIndexWidth-1:0] regIndex;

  assign selected = cs == boardSelect;
  assign op = ebusPkg::diagOp'(ds[ebusPkg::diagOpLsb +: ebusPkg::diagOpWidth]);
  assign regIndex = ds[ebusPkg::diagRegIndexWidth-1:0];

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) begin
      for (int i = 0; i < ebusPkg::diagRegCount; i++) begin
        diagRegs[i] <= '0;
      end
    end else if (diagStrobe && selected) begin
      if (op == ebusPkg::diagWrite) begin
        diagRegs[regIndex] <= dataOut;
      end else if (op == ebusPkg::diagClear) begin
        for (int i = 0; i < ebusPkg::diagRegCount; i++) begin
          diagRegs[i] <= '0;  // clear hits the whole board
        end
      end
    end
  end

  // drive the bus only while our select is up during the read phase
  assign driving = selected && readPhase && op == ebusPkg::diagRead;
  assign data = driving ? diagRegs[regIndex] : '0;

endmodule

// File: ebusMux.sv
`timescale 1ns/1ps

module ebusMux (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic [ebusPkg::boardCount-1:0] boardDriving,
  input  logic [ebusPkg::boardCount-1:0][ebusPkg::ebusDataWidth-1:0] boardData,
  output logic [ebusPkg::ebusDataWidth-1:0] ebusData,
  output logic dataValid
);

  logic anyBoardDriving;
  logic [ebusPkg::ebusDataWidth-1:0] drivenData;

  assign anyBoardDriving = |boardDriving;

  // selects are unique so at most one flag is set, and an and-or picks it
  always_comb begin
    drivenData = '0;
    for (int i = 0; i < ebusPkg::boardCount; i++) begin
      drivenData = drivenData | (boardData[i] & {ebusPkg::ebusDataWidth{boardDriving[i]}});
    end
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (reset) dataValid <= 1'b0;
    else dataValid <= anyBoardDriving;
  end

  always_ff @(posedge anyEBUSdriving) begin
    if (anyBoardDriving) ebusData <= drivenData;  // holds the last driven word otherwise
  end

endmodule

// File: ebusSubsystem.sv
`timescale 1ns/1ps

module ebusSubsystem (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic [hostPkg::addrWidth-1:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [hostPkg::axiDataWidth-1:0] wdata,
  input  logic [hostPkg::axiStrbWidth-1:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  input  logic [hostPkg::addrWidth-1:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [hostPkg::axiDataWidth-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready
);

  logic start;
  logic [ebusPkg::ebusSelWidth-1:0] csSel;
  logic [ebusPkg::ebusSelWidth-1:0] dsSel;
  logic [ebusPkg::ebusDataWidth-1:0] writeData;
  logic busy;
  logic done;
  logic timedOut;
  logic [ebusPkg::ebusDataWidth-1:0] readData;

  // EBUS lines
  logic [ebusPkg::ebusSelWidth-1:0] cs;
  logic [ebusPkg::ebusSelWidth-1:0] ds;
  logic diagStrobe;
  logic readPhase;
  logic [ebusPkg::ebusDataWidth-1:0] dataOut;
  logic dataValid;
  logic [ebusPkg::ebusDataWidth-1:0] ebusData;
  logic [ebusPkg::boardCount-1:0] boardDriving;
  logic [ebusPkg::boardCount-1:0][ebusPkg::ebusDataWidth-1:0] boardData;

  hostRegs hostRegs (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .start(start), .csSel(csSel), .dsSel(dsSel), .writeData(writeData),
    .busy(busy), .done(done), .timedOut(timedOut), .readData(readData)
  );

  diagSequencer diagSequencer (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset), .start(start),
    .csSel(csSel), .dsSel(dsSel), .writeData(writeData),
    .cs(cs), .ds(ds), .diagStrobe(diagStrobe), .readPhase(readPhase),
    .dataOut(dataOut), .dataValid(dataValid), .ebusData(ebusData),
    .busy(busy), .done(done), .timedOut(timedOut), .readData(readData)
  );

  ebusMux ebusMux (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset),
    .boardDriving(boardDriving), .boardData(boardData),
    .ebusData(ebusData), .dataValid(dataValid)
  );

  diagBoard #(.boardSelect(ebusPkg::aprSelect)) aprBoard (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset), .cs(cs), .ds(ds),
    .diagStrobe(diagStrobe), .readPhase(readPhase), .dataOut(dataOut),
    .driving(boardDriving[0]), .data(boardData[0])
  );

  diagBoard #(.boardSelect(ebusPkg::cshSelect)) cshBoard (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset), .cs(cs), .ds(ds),
    .diagStrobe(diagStrobe), .readPhase(readPhase), .dataOut(dataOut),
    .driving(boardDriving[1]), .data(boardData[1])
  );

  diagBoard #(.boardSelect(ebusPkg::ctlSelect)) ctlBoard (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset), .cs(cs), .ds(ds),
    .diagStrobe(diagStrobe), .readPhase(readPhase), .dataOut(dataOut),
    .driving(boardDriving[2]), .data(boardData[2])
  );

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int halfPeriod = 20,
  parameter int resetCycles = 16
) (
  output logic anyEBUSdriving,
  output logic reset
);

  initial begin
    anyEBUSdriving = 1'b0;
    forever #halfPeriod anyEBUSdriving = ~anyEBUSdriving;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge anyEBUSdriving);
    @(negedge anyEBUSdriving);
    reset = 1'b0;  // released on a falling edge like every other input
  end

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
  input  logic anyEBUSdriving,
  input  logic reset,
  input  logic [hostPkg::addrWidth-1:0] araddr,
  input  logic arvalid,
  input  logic arready,
  input  logic [31:0] rdata,
  input  logic [1:0] rresp,
  input  logic rvalid,
  input  logic rready,
  input  logic awvalid,
  input  logic awready,
  input  logic wvalid,
  input  logic wready,
  input  logic [1:0] bresp,
  input  logic bvalid,
  input  logic bready,
  input  int rowIndex,
  input  logic [6:0] rowCs,
  input  ebusPkg::diagOp rowOp,
  input  logic [1:0] rowReg,
  input  logic [35:0] rowData,
  input  logic rowTimeout,
  input  logic rowDone,
  output int checkCount,
  output int errorCount
);

  logic [35:0] model [3][4];  // three boards of four registers
  logic [hostPkg::addrWidth-1:0] readAddr;
  int rowErrors;
  int writesTaken;  // address handshakes since the last write response

  function automatic int boardOf(input logic [6:0] sel);
    if (sel == ebusPkg::aprSelect) return 0;
    if (sel == ebusPkg::cshSelect) return 1;
    if (sel == ebusPkg::ctlSelect) return 2;
    return -1;  // no board answers
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      rowErrors++;
      $display("CHECK FAILED at %0d ns: %s expected %h actual %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic checkRead();
    logic [35:0] expWord;
    logic [31:0] expStatus;
    logic checkData;
    int b;
    b = boardOf(rowCs);
    expWord = '0;
    if (rowIndex >= 0 && rowOp == ebusPkg::diagRead && b >= 0) expWord = model[b][rowReg];
    expStatus = '0;
    expStatus[hostPkg::statusDone] = rowIndex >= 0;
    expStatus[hostPkg::statusTimeout] = rowIndex >= 0 && rowTimeout;
    checkData = rowIndex < 0 || rowOp == ebusPkg::diagRead;
    compare("rresp", 32'h0, {30'h0, rresp});
    case (readAddr)
      // polls taken before done only show busy
      hostPkg::regStatus:
        if (rowIndex < 0 || rdata[hostPkg::statusDone]) compare("regStatus", expStatus, rdata);
      hostPkg::regReadLow: if (checkData) compare("regReadLow", expWord[31:0], rdata);
      hostPkg::regReadHigh: if (checkData) compare("regReadHigh", {28'h0, expWord[35:32]}, rdata);
      hostPkg::regControl: compare("regControl", 32'h0, rdata);
      default: if (rowIndex < 0) compare("rdata", 32'h0, rdata);
    endcase
  endtask

  task automatic finishRow();
    int b;
    b = boardOf(rowCs);
    if (rowIndex >= 0 && b >= 0) begin
      if (rowOp == ebusPkg::diagWrite) begin
        model[b][rowReg] = rowData;
      end else if (rowOp == ebusPkg::diagClear) begin
        for (int i = 0; i < 4; i++) model[b][i] = '0;
      end
    end
    if (rowIndex < 0) $display("reset sweep: %0d errors", rowErrors);
    else $display("row %0d cs %o %s reg %0d: %0d errors",
                  rowIndex, rowCs, rowOp.name(), rowReg, rowErrors);
    rowErrors = 0;
  endtask

  always @(posedge anyEBUSdriving) begin
    if (reset) begin
      for (int b = 0; b < 3; b++) begin
        for (int i = 0; i < 4; i++) model[b][i] = '0;
      end
      readAddr = '0;
      rowErrors = 0;
      writesTaken = 0;
      checkCount = 0;
      errorCount = 0;
    end else begin
      if (arvalid && arready) readAddr = araddr;
      if (awvalid && awready) begin
        writesTaken++;
        compare("wready", 32'h1, {31'h0, wvalid && wready});  // data goes with the address
      end
      if (bvalid && bready) begin
        compare("bresp", 32'h0, {30'h0, bresp});
        compare("awready", 32'h1, writesTaken);  // one accepted write per response
        writesTaken = 0;
      end
      if (rvalid && rready) checkRead();
      if (rowDone) finishRow();
    end
  end

endmodule

// File: tbTop.sv
`timescale 1ns/1ps

module tbTop;

  localparam int axiCycles = 40;  // clock budget per row for the AXI traffic

  logic anyEBUSdriving;
  logic reset;
  logic [hostPkg::addrWidth-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;

  // row currently running, shared with the checker
  int rowIndex;
  logic [6:0] rowCs;
  ebusPkg::diagOp rowOp;
  logic [1:0] rowReg;
  logic [35:0] rowData;
  logic rowTimeout, rowDone;

  int checkCount, errorCount;
  int cycles = 0;
  int cycleLimit = 0;
  int seed;

  // stimulus table; expected read data comes from the checker's register model
  logic [6:0] tabCs [$];
  ebusPkg::diagOp tabOp [$];
  logic [1:0] tabReg [$];
  logic tabRandom [$];
  logic [35:0] tabData [$];
  logic tabTimeout [$];

  tbClock clockGen (.anyEBUSdriving(anyEBUSdriving), .reset(reset));

  ebusSubsystem i_dut (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  tbChecker scoreboard (
    .anyEBUSdriving(anyEBUSdriving), .reset(reset),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .rowIndex(rowIndex), .rowCs(rowCs), .rowOp(rowOp), .rowReg(rowReg),
    .rowData(rowData), .rowTimeout(rowTimeout), .rowDone(rowDone),
    .checkCount(checkCount), .errorCount(errorCount)
  );

  task automatic axiWrite(input logic [hostPkg::addrWidth-1:0] addr, input logic [31:0] data);
    @(negedge anyEBUSdriving);
    awaddr = addr;
    wdata = data;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    do @(negedge anyEBUSdriving); while (!bvalid);
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge anyEBUSdriving);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [hostPkg::addrWidth-1:0] addr, output logic [31:0] data);
    @(negedge anyEBUSdriving);
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    do @(negedge anyEBUSdriving); while (!rvalid);
    data = rdata;
    arvalid = 1'b0;
    @(negedge anyEBUSdriving);
    rready = 1'b0;
  endtask

  task automatic pulseRowDone();
    @(negedge anyEBUSdriving);
    rowDone = 1'b1;
    @(negedge anyEBUSdriving);
    rowDone = 1'b0;
  endtask

  task automatic addRow(input logic [6:0] cs, input ebusPkg::diagOp op, input logic [1:0] idx,
                        input logic rnd, input logic [35:0] data, input logic expTimeout);
    tabCs.push_back(cs);
    tabOp.push_back(op);
    tabReg.push_back(idx);
    tabRandom.push_back(rnd);
    tabData.push_back(data);
    tabTimeout.push_back(expTimeout);
  endtask

  task automatic buildTable();
    logic [6:0] sel [3];
    sel[0] = ebusPkg::aprSelect;
    sel[1] = ebusPkg::cshSelect;
    sel[2] = ebusPkg::ctlSelect;
    // every register starts at zero, then gets its own random word, then reads back
    for (int b = 0; b < 3; b++) begin
      for (int i = 0; i < 4; i++) addRow(sel[b], ebusPkg::diagRead, 2'(i), 1'b0, '0, 1'b0);
    end
    for (int b = 0; b < 3; b++) begin
      for (int i = 0; i < 4; i++) addRow(sel[b], ebusPkg::diagWrite, 2'(i), 1'b1, '0, 1'b0);
    end
    for (int b = 0; b < 3; b++) begin
      for (int i = 0; i < 4; i++) addRow(sel[b], ebusPkg::diagRead, 2'(i), 1'b0, '0, 1'b0);
    end
    addRow(ebusPkg::ctlSelect, ebusPkg::diagWrite, 2'd2, 1'b0, 36'hF_0F0F_0F0F, 1'b0);
    for (int b = 0; b < 3; b++) addRow(sel[b], ebusPkg::diagRead, 2'd2, 1'b0, '0, 1'b0);
    addRow(ebusPkg::cshSelect, ebusPkg::diagClear, 2'd0, 1'b0, '0, 1'b0);
    for (int i = 0; i < 4; i++) addRow(sel[1], ebusPkg::diagRead, 2'(i), 1'b0, '0, 1'b0);
    addRow(ebusPkg::aprSelect, ebusPkg::diagRead, 2'd1, 1'b0, '0, 1'b0);
    addRow(ebusPkg::ctlSelect, ebusPkg::diagRead, 2'd3, 1'b0, '0, 1'b0);
    addRow(7'o11, ebusPkg::diagRead, 2'd0, 1'b0, '0, 1'b1);  // empty slot must time out
    addRow(ebusPkg::aprSelect, ebusPkg::diagRead, 2'd0, 1'b0, '0, 1'b0);
  endtask

  task automatic runRow(input int r);
    logic [35:0] data;
    logic [31:0] word;
    logic [31:0] status;
    data = tabData[r];
    if (tabRandom[r]) begin
      word = $random(seed);
      data[31:0] = word;
      word = $random(seed);
      data[35:32] = word[3:0];
    end
    @(negedge anyEBUSdriving);
    rowIndex = r;
    rowCs = tabCs[r];
    rowOp = tabOp[r];
    rowReg = tabReg[r];
    rowData = data;
    rowTimeout = tabTimeout[r];
    // ds carries the function in bits 6..4 and the register in bits 1..0
    axiWrite(hostPkg::regSelect, {16'h0, 1'b0, tabOp[r], 2'b00, tabReg[r], 1'b0, tabCs[r]});
    axiWrite(hostPkg::regWriteLow, data[31:0]);
    axiWrite(hostPkg::regWriteHigh, {28'h0, data[35:32]});
    axiWrite(hostPkg::regControl, 32'h1);
    status = '0;
    while (!status[hostPkg::statusDone]) axiRead(hostPkg::regStatus, status);
    axiRead(hostPkg::regControl, word);
    axiRead(hostPkg::regReadLow, word);
    axiRead(hostPkg::regReadHigh, word);
    pulseRowDone();
  endtask

  always @(posedge anyEBUSdriving) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("run timed out after %0d clock cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0] word;
    seed = 32'h29e5bcf5;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    rowIndex = -1;
    rowCs = '0;
    rowOp = ebusPkg::diagRead;
    rowReg = '0;
    rowData = '0;
    rowTimeout = 1'b0;
    rowDone = 1'b0;
    buildTable();
    // one extra row budget covers reset and the register sweep
    cycleLimit = (tabCs.size() + 1) * (ebusPkg::diagTimeout + axiCycles) + 16;
    wait (reset === 1'b0);
    for (int a = 0; a < 8; a++) axiRead(8'(a * 4), word);  // every host offset reads 0
    pulseRowDone();
    for (int r = 0; r < tabCs.size(); r++) runRow(r);
    $display("%0d rows, %0d checks, %0d errors", tabCs.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sim.f
ebusPkg.sv
hostPkg.sv
hostRegs.sv
diagSequencer.sv
diagBoard.sv
ebusMux.sv
ebusSubsystem.sv
tbClock.sv
tbChecker.sv
tbTop.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module tbTop -o simv

run: build
	./obj_dir/simv | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not finish"; exit 1)

lint:
	verilator --lint-only --timing -f sim.f --top-module tbTop

clean:
	rm -rf obj_dir sim.log
